// ==== hw/flstory_pkg.sv ====
// shared definitions for the sub processor board
//   memory map constants and shared RAM geometry
//   interrupt entry vectors
//   opcode set of the compact sub CPU
//   bus structs between CPU, decoder and shared RAM
package flstory_pkg;

    //////////////////////////////////////////////////
    // memory map
    //////////////////////////////////////////////////
    localparam logic [1:0]  ROM_TOP_BANK = 2'd3;        // A[15:14] value of the shared bus
    localparam int          SHRAM_AW     = 11;          // 2 KB shared RAM
    localparam logic [15:0] SHRAM_BASE   = 16'hC000;    // first mirror of the shared RAM

    localparam logic [15:0] INT_VECTOR   = 16'h0038;    // level interrupt entry
    localparam logic [15:0] NMI_VECTOR   = 16'h0066;    // nmi entry

    //////////////////////////////////////////////////
    // opcodes, any other byte runs as a nop
    //////////////////////////////////////////////////
    localparam logic [7:0] OP_LDI  = 8'h3E;     // a = imm
    localparam logic [7:0] OP_LDA  = 8'h3A;     // a = [nn]
    localparam logic [7:0] OP_STA  = 8'h32;     // [nn] = a
    localparam logic [7:0] OP_ADD  = 8'h86;     // a += [nn]
    localparam logic [7:0] OP_ADI  = 8'hC6;     // a += imm
    localparam logic [7:0] OP_JP   = 8'hC3;     // pc = nn
    localparam logic [7:0] OP_JZ   = 8'hCA;     // pc = nn if zero
    localparam logic [7:0] OP_EI   = 8'hFB;
    localparam logic [7:0] OP_RETI = 8'h4D;     // return, interrupt back on
    localparam logic [7:0] OP_RETN = 8'h45;     // return from nmi, enable restored
    localparam logic [7:0] OP_HALT = 8'h76;

    // CPU bus outputs, flags active high
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        mreq;
        logic        rd;
        logic        wr;
    } cpu_bus_t;

    // main CPU side of the shared RAM
    typedef struct packed {
        logic                cs;
        logic                wr;
        logic [SHRAM_AW-1:0] addr;
        logic [7:0]          din;
    } main_req_t;

    // sub CPU side of the shared RAM
    typedef struct packed {
        logic                cs;
        logic                wr;
        logic [SHRAM_AW-1:0] addr;
        logic [7:0]          din;
    } sub_ram_req_t;

endpackage

// ==== hw/flstory_sub_cpu.sv ====
// compact 8-bit accumulator CPU for the sub board
//   one memory cycle per enabled clock, held while rom_ok is low
//   nmi edge latch, level interrupt with enable, return register
//   bus request and acknowledge at instruction boundaries
`timescale 1ns/1ps

module flstory_sub_cpu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen,
    input  logic                  int_n,
    input  logic                  nmi_n,
    input  logic                  busrq_n,
    input  logic                  rom_ok,
    input  logic                  rom_cs,      // current cycle waits on rom_ok
    input  logic [7:0]            din,
    output flstory_pkg::cpu_bus_t bus,
    output logic                  busak_n
);
    import flstory_pkg::*;

    typedef enum logic [2:0] {
        S_BOUND,    // instruction boundary, no memory cycle
        S_FETCH,    // opcode fetch
        S_OP1,      // immediate or address low
        S_OP2,      // address high
        S_MEM,      // data read or write
        S_HALT,
        S_BUSAK     // bus handed over
    } state_t;

    state_t      state;
    logic [15:0] pc;
    logic [15:0] ea;        // effective address of the data cycle
    logic [15:0] ret_pc;    // shared by int and nmi
    logic [7:0]  a;
    logic [7:0]  ir;
    logic [7:0]  sum;
    logic        zf;
    logic        ie;
    logic        ie_save;   // enable before the nmi
    logic        nmi_q;
    logic        nmi_pend;
    logic        step;
    logic        take_nmi;
    logic        take_int;
    logic        wake;

    assign step     = cen & ~(rom_cs & ~rom_ok);    // memory cycle completes
    assign take_nmi = cen & (state == S_BOUND) & nmi_pend;
    assign take_int = cen & (state == S_BOUND) & ~nmi_pend & ~int_n & ie;
    assign wake     = nmi_pend | (~int_n & ie) | ~busrq_n;
    assign sum      = a + din;                      // 8-bit wrap

    //////////////////////////////////////////////////
    // bus outputs straight from state
    //////////////////////////////////////////////////
    always_comb begin
        bus.mreq = (state == S_FETCH) || (state == S_OP1) ||
                   (state == S_OP2) || (state == S_MEM);
        bus.wr   = (state == S_MEM) && (ir == OP_STA);
        bus.rd   = bus.mreq && !bus.wr;
        bus.addr = (state == S_MEM) ? ea : pc;
        bus.dout = a;
    end

    assign busak_n = (state != S_BUSAK);

    // control state and registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_BOUND;            // first boundary leads to a fetch at 0
            pc       <= '0;
            a        <= '0;
            zf       <= 1'b0;
            ie       <= 1'b0;
            ie_save  <= 1'b0;
            nmi_q    <= 1'b1;
            nmi_pend <= 1'b0;
        end else begin
            nmi_q <= nmi_n;
            if (take_nmi) nmi_pend <= 1'b0;
            if (nmi_q && !nmi_n) nmi_pend <= 1'b1;  // new edge wins over the clear
            case (state)
                S_BOUND: if (cen) begin
                    if (take_nmi) begin
                        pc      <= NMI_VECTOR;
                        ie_save <= ie;
                        ie      <= 1'b0;
                        state   <= S_FETCH;
                    end else if (take_int) begin
                        pc    <= INT_VECTOR;
                        ie    <= 1'b0;                  // taken clears the enable
                        state <= S_FETCH;
                    end else if (!busrq_n) begin
                        state <= S_BUSAK;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                S_FETCH: if (step) begin
                    pc <= pc + 16'd1;
                    case (din)
                        OP_LDI, OP_ADI, OP_LDA, OP_STA,
                        OP_ADD, OP_JP, OP_JZ: state <= S_OP1;
                        OP_EI: begin
                            ie    <= 1'b1;
                            state <= S_BOUND;
                        end
                        OP_RETI: begin
                            pc    <= ret_pc;
                            ie    <= 1'b1;
                            state <= S_BOUND;
                        end
                        OP_RETN: begin
                            pc    <= ret_pc;
                            ie    <= ie_save;
                            state <= S_BOUND;
                        end
                        OP_HALT: state <= S_HALT;
                        default: state <= S_BOUND;      // nop
                    endcase
                end
                S_OP1: if (step) begin
                    pc <= pc + 16'd1;
                    if (ir == OP_LDI) begin
                        a     <= din;
                        zf    <= (din == 8'd0);
                        state <= S_BOUND;
                    end else if (ir == OP_ADI) begin
                        a     <= sum;
                        zf    <= (sum == 8'd0);
                        state <= S_BOUND;
                    end else begin
                        state <= S_OP2;
                    end
                end
                S_OP2: if (step) begin
                    pc <= pc + 16'd1;
                    if (ir == OP_JP) begin
                        pc    <= {din, ea[7:0]};
                        state <= S_BOUND;
                    end else if (ir == OP_JZ) begin
                        if (zf) pc <= {din, ea[7:0]};
                        state <= S_BOUND;
                    end else begin
                        state <= S_MEM;
                    end
                end
                S_MEM: if (step) begin
                    if (ir == OP_LDA) begin
                        a  <= din;
                        zf <= (din == 8'd0);
                    end else if (ir == OP_ADD) begin
                        a  <= sum;
                        zf <= (sum == 8'd0);
                    end
                    state <= S_BOUND;
                end
                S_HALT:  if (cen && wake) state <= S_BOUND;     // pc already past halt
                S_BUSAK: if (cen && busrq_n) state <= S_BOUND;
                default: state <= S_BOUND;
            endcase
        end
    end

    // opcode, address and return payload
    always_ff @(posedge clk) begin
        if (step && state == S_FETCH) ir <= din;
        if (step && state == S_OP1) ea[7:0] <= din;
        if (step && state == S_OP2) ea[15:8] <= din;
        if (take_nmi || take_int) ret_pc <= pc;
    end

endmodule

// ==== hw/flstory_sub.sv ====
// sub board CPU wrapper
//   address decode into ROM and shared bus
//   read data mux, paused vblank interrupt
//   clock enable stalled by bus wait, registered CPU reset
`timescale 1ns/1ps

module flstory_sub (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      enable,
    input  logic                      cen,
    input  logic                      lvbl,         // low during vblank
    input  logic                      nmi_n,
    input  logic                      dip_pause,
    input  logic                      busrq_n,
    input  logic                      bus_rstn,
    input  logic                      bus_wait,
    input  logic [7:0]                bus_din,
    input  logic [7:0]                rom_data,
    input  logic                      rom_ok,
    output logic                      rom_cs,
    output logic [15:0]               rom_addr,
    output flstory_pkg::sub_ram_req_t ram_req,
    output logic                      busak_n
);
    import flstory_pkg::*;

    cpu_bus_t    cpu_bus;
    logic        bus_cs;
    logic [15:0] bus_offs;
    logic [7:0]  cpu_din;
    logic        bus_cen;
    logic        int_n;
    logic        cpu_rst_n;

    assign int_n    = ~dip_pause | lvbl;        // pause blocks the vblank irq
    assign bus_cen  = cen & ~bus_wait;          // stall while main owns the RAM
    assign rom_addr = cpu_bus.addr;
    assign bus_offs = cpu_bus.addr - SHRAM_BASE;    // mirrors every 2 KB

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////
    always_comb begin
        rom_cs = 1'b0;
        bus_cs = 1'b0;
        if (cpu_bus.mreq && (cpu_bus.rd || cpu_bus.wr)) begin
            if (cpu_bus.addr[15:14] == ROM_TOP_BANK) bus_cs = 1'b1;
            else rom_cs = 1'b1;                 // 0000-BFFF
        end
    end

    assign cpu_din = rom_cs ? rom_data : bus_din;

    always_comb begin
        ram_req.cs   = bus_cs;
        ram_req.wr   = cpu_bus.wr;
        ram_req.addr = bus_offs[SHRAM_AW-1:0];
        ram_req.din  = cpu_bus.dout;
    end

    // CPU leaves reset one clock after all sources release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) cpu_rst_n <= 1'b0;
        else cpu_rst_n <= enable & bus_rstn;
    end

    flstory_sub_cpu i_cpu (
        .clk     (clk),
        .rst_n   (cpu_rst_n),
        .cen     (bus_cen),
        .int_n   (int_n),
        .nmi_n   (nmi_n),
        .busrq_n (busrq_n),
        .rom_ok  (rom_ok),
        .rom_cs  (rom_cs),
        .din     (cpu_din),
        .bus     (cpu_bus),
        .busak_n (busak_n)
    );

endmodule

// ==== hw/flstory_shared_ram.sv ====
// 2 KB shared RAM between main and sub CPUs
//   single write port, main side has fixed priority
//   main reads registered, sub reads combinational
//   sub gets a wait on collision and retries
`timescale 1ns/1ps

module flstory_shared_ram (
    input  logic                      clk,
    input  flstory_pkg::main_req_t    main,
    output logic [7:0]                main_dout,
    input  flstory_pkg::sub_ram_req_t sub,
    output logic [7:0]                sub_dout,
    output logic                      wait_sub
);
    import flstory_pkg::*;

    localparam int DEPTH = 2 ** SHRAM_AW;

    logic [7:0]          mem [0:DEPTH-1];
    logic                port_we;
    logic [SHRAM_AW-1:0] port_addr;
    logic [7:0]          port_din;

    //////////////////////////////////////////////////
    // arbiter
    //////////////////////////////////////////////////
    assign wait_sub = sub.cs & main.cs;     // main wins, sub repeats

    always_comb begin
        if (main.cs) begin
            port_we   = main.wr;
            port_addr = main.addr;
            port_din  = main.din;
        end else begin
            port_we   = sub.cs & sub.wr;
            port_addr = sub.addr;
            port_din  = sub.din;
        end
    end

    // single write port
    always_ff @(posedge clk) begin
        if (port_we) mem[port_addr] <= port_din;
    end

    // main read data one clock after cs, old data on a write
    always_ff @(posedge clk) begin
        if (main.cs) main_dout <= mem[main.addr];
    end

    // sub samples this on its enabled edge
    assign sub_dout = mem[sub.addr];

endmodule

// ==== hw/flstory_sub_top.sv ====
// top level of the sub processor board
//   sub CPU wrapper and shared RAM
//   ROM port, main CPU port and control inputs
`timescale 1ns/1ps

module flstory_sub_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // program ROM
    output logic [15:0]            rom_addr,
    output logic                   rom_cs,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok,
    // main CPU side
    input  flstory_pkg::main_req_t main,
    output logic [7:0]             main_dout,
    // control
    input  logic                   enable,
    input  logic                   bus_rstn,
    input  logic                   lvbl,
    input  logic                   nmi_n,
    input  logic                   dip_pause,
    input  logic                   busrq_n,
    input  logic                   cen,
    output logic                   busak_n
);
    import flstory_pkg::*;

    sub_ram_req_t ram_req;
    logic [7:0]   bus_din;
    logic         bus_wait;

    flstory_sub i_sub (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .cen       (cen),
        .lvbl      (lvbl),
        .nmi_n     (nmi_n),
        .dip_pause (dip_pause),
        .busrq_n   (busrq_n),
        .bus_rstn  (bus_rstn),
        .bus_wait  (bus_wait),
        .bus_din   (bus_din),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .ram_req   (ram_req),
        .busak_n   (busak_n)
    );

    flstory_shared_ram i_shram (
        .clk       (clk),
        .main      (main),
        .main_dout (main_dout),
        .sub       (ram_req),
        .sub_dout  (bus_din),
        .wait_sub  (bus_wait)
    );

endmodule

// ==== tb/flstory_rom_model.sv ====
// program ROM model for the sub CPU
//   64 KB byte array, written by tasks per test
//   rom_ok after a latency taken from lat at the end of each access
`timescale 1ns/1ps

module flstory_rom_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] addr,
    input  logic        cs,
    input  logic [2:0]  lat,        // latency of the next access
    output logic [7:0]  data,
    output logic        ok
);
    logic [7:0] mem [0:65535];
    logic [2:0] cnt;
    logic [2:0] cur_lat;

    assign ok   = cs && (cnt >= cur_lat);
    assign data = ok ? mem[addr] : 8'hxx;   // no data before ok

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            cur_lat <= '0;
        end else if (cs && ok) begin
            cnt     <= '0;                  // access done, pick next delay
            cur_lat <= lat;
        end else if (cs) begin
            cnt <= cnt + 3'd1;
        end
    end

    // erase before a new program
    task automatic clear();
        for (int i = 0; i < 65536; i++) mem[i] = 8'h00;
    endtask

    task automatic put(input logic [15:0] a, input logic [7:0] d);
        mem[a] = d;
    endtask

endmodule

// ==== tb/flstory_sub_tb.sv ====
// testbench for the sub processor board
//   clock, reset, table of tests applied in a loop
//   main port polling of the marker, contention, interrupts, bus request
//   check task, watchdog and summary
`timescale 1ns/1ps

module flstory_sub_tb;
    import flstory_pkg::*;

    localparam logic [10:0] MARK_A = 11'h7FF;   // 0xC7FF seen from main
    localparam logic [7:0]  SENT   = 8'hEE;     // preloaded marker value

    typedef struct {
        string      name;
        int         prog;
        bit         pause;
        int         lvbl_per;   // 0 keeps lvbl high
        int         nmi_at;     // negative means no pulse
        bit         en;
        bit         brst;
        int         rq_from;
        int         rq_to;      // equal to rq_from means no window
        bit         cont;
        bit         rnd;
        bit         wait_all;   // run the whole budget before the check
        logic [7:0] expv;
        int         budget;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic [15:0] rom_addr;
    logic        rom_cs;
    logic [7:0]  rom_data;
    logic        rom_ok;
    logic [2:0]  rom_lat;
    main_req_t   main_req;
    logic [7:0]  main_dout;
    logic        enable;
    logic        bus_rstn;
    logic        lvbl;
    logic        nmi_n;
    logic        dip_pause;
    logic        busrq_n;
    logic        cen;
    logic        busak_n;

    row_t        rows[$];
    bit          table_ready;
    int          errors;
    int          failed;
    logic [31:0] rng;
    logic [15:0] org;

    flstory_sub_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
        .main(main_req), .main_dout(main_dout),
        .enable(enable), .bus_rstn(bus_rstn), .lvbl(lvbl), .nmi_n(nmi_n),
        .dip_pause(dip_pause), .busrq_n(busrq_n), .cen(cen), .busak_n(busak_n)
    );

    flstory_rom_model i_rom (
        .clk(clk), .rst_n(rst_n), .addr(rom_addr), .cs(rom_cs),
        .lat(rom_lat), .data(rom_data), .ok(rom_ok)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    task automatic check_eq(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", what, exp, act);
            errors++;
        end
    endtask

    task automatic add_row(input string n, input int p, input bit pz, input int lp,
                           input int na, input bit e, input bit b, input int rf, input int rt,
                           input bit c, input bit rn, input bit w, input logic [7:0] x,
                           input int bg);
        row_t r;
        r = '{n, p, pz, lp, na, e, b, rf, rt, c, rn, w, x, bg};
        rows.push_back(r);
    endtask

    // one instruction of up to three bytes at org
    task automatic emit(input int n, input logic [7:0] b0, input logic [7:0] b1,
                        input logic [7:0] b2);
        i_rom.put(org, b0);
        if (n > 1) i_rom.put(org + 16'd1, b1);
        if (n > 2) i_rom.put(org + 16'd2, b2);
        org = org + 16'(n);
    endtask

    task automatic load_program(input int sel);
        i_rom.clear();
        org = 16'h0000;
        if (sel == 0) begin                     // arithmetic, store, add back
            emit(2, OP_LDI, 8'hA7, 8'h00);
            emit(2, OP_ADI, 8'h6B, 8'h00);
            emit(3, OP_STA, 8'h10, 8'hC0);
            emit(3, OP_ADD, 8'h10, 8'hC0);
            emit(3, OP_STA, 8'hFF, 8'hC7);
            emit(1, OP_HALT, 8'h00, 8'h00);
        end else if (sel == 1) begin            // works on the main seed
            emit(2, OP_LDI, 8'h11, 8'h00);
            emit(3, OP_ADD, 8'h20, 8'hC0);
            emit(3, OP_STA, 8'h21, 8'hC0);
            emit(3, OP_ADD, 8'h21, 8'hC0);
            emit(3, OP_STA, 8'hFF, 8'hC7);
            emit(1, OP_HALT, 8'h00, 8'h00);
        end else begin                          // main loop writes 0x11 then spins
            emit(2, OP_LDI, 8'h11, 8'h00);
            emit(3, OP_STA, 8'hFF, 8'hC7);
            if (sel == 2) emit(1, OP_EI, 8'h00, 8'h00);
            emit(3, OP_JP, org[7:0], org[15:8]);
            org = (sel == 2) ? INT_VECTOR : NMI_VECTOR;
            emit(2, OP_LDI, (sel == 2) ? 8'h55 : 8'hA5, 8'h00);
            emit(3, OP_STA, 8'hFF, 8'hC7);
            emit(1, (sel == 2) ? OP_RETI : OP_RETN, 8'h00, 8'h00);
        end
    endtask

    task automatic main_drive(input logic cs, input logic wr, input logic [10:0] a,
                              input logic [7:0] d);
        main_req.cs   = cs;
        main_req.wr   = wr;
        main_req.addr = a;
        main_req.din  = d;
    endtask

    task automatic main_read(input logic [10:0] a, output logic [7:0] d);
        @(posedge clk);
        #1;
        main_drive(1'b1, 1'b0, a, 8'h00);
        @(posedge clk);
        #1;
        main_drive(1'b0, 1'b0, 11'h0, 8'h00);
        d = main_dout;
    endtask

    ////////////////////////////////////////////////////
    // one row of the table
    ////////////////////////////////////////////////////
    task automatic run_test(input row_t t);
        logic [7:0]  marker;
        logic [7:0]  held;
        logic [7:0]  val;
        logic [31:0] r;
        logic        rd_pend;
        logic [10:0] rd_addr;
        bit          done;
        bit          ak_seen;
        int          err0;

        err0    = errors;
        marker  = SENT;
        held    = SENT;
        rd_pend = 1'b0;
        rd_addr = '0;
        done    = 0;
        ak_seen = 0;
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        enable    = t.en;
        bus_rstn  = t.brst;
        dip_pause = t.pause;
        lvbl      = 1'b1;
        nmi_n     = 1'b1;
        busrq_n   = 1'b1;
        rom_lat   = 3'd0;
        load_program(t.prog);
        main_drive(1'b1, 1'b1, MARK_A, SENT);   // preload while the CPU is held
        @(posedge clk);
        #1;
        main_drive(1'b1, 1'b1, 11'h010, 8'h00);
        @(posedge clk);
        #1;
        main_drive(1'b1, 1'b1, 11'h020, 8'h33);
        @(posedge clk);
        #1;
        main_drive(1'b1, 1'b1, 11'h021, 8'h00);
        @(posedge clk);
        #1;
        main_drive(1'b0, 1'b0, 11'h0, 8'h00);
        repeat (6) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int cyc = 0; cyc < t.budget && !done; cyc++) begin
            @(posedge clk);
            #1;
            if (rd_pend && rd_addr == MARK_A) begin
                marker = main_dout;
                if (!busrq_n) held = marker;    // must not move under bus request
            end else if (rd_pend) begin
                check_eq({t.name, " main read"}, 8'h33, main_dout);
            end
            if (!busak_n) ak_seen = 1;
            if (!t.wait_all && marker == t.expv) done = 1;
            lvbl    = !(t.lvbl_per != 0 && (cyc % t.lvbl_per) < 4);
            nmi_n   = !(t.nmi_at >= 0 && cyc >= t.nmi_at && cyc < t.nmi_at + 2);
            busrq_n = !(cyc >= t.rq_from && cyc < t.rq_to);
            r       = lcg();
            rom_lat = t.rnd ? 3'((r >> 16) % 6) : 3'd0;
            if (cyc % 8 == 0) main_drive(1'b1, 1'b0, MARK_A, 8'h00);
            else if (t.cont && r[27]) main_drive(1'b1, 1'b0, 11'h020, 8'h00);
            else main_drive(1'b0, 1'b0, 11'h0, 8'h00);
            rd_pend = main_req.cs;
            rd_addr = main_req.addr;
        end
        main_drive(1'b0, 1'b0, 11'h0, 8'h00);
        busrq_n = 1'b1;
        if (!done && !t.wait_all) begin
            $display("ERROR %s: program never finished within %0d cycles", t.name, t.budget);
            errors++;
        end
        main_read(MARK_A, val);
        check_eq(t.name, t.expv, val);
        if (t.cont) begin
            main_read(11'h021, val);
            check_eq({t.name, " partial sum"}, 8'(8'h11 + 8'h33), val);
        end
        if (t.rq_to > t.rq_from) begin
            check_eq({t.name, " marker held"}, SENT, held);
            check_eq({t.name, " busak_n low"}, 8'd1, {7'd0, ak_seen});
        end
        if (errors != err0) failed++;
        $display("test %s: %s", t.name, (errors == err0) ? "ok" : "failed");
    endtask

    // watchdog sized from the table
    initial begin
        longint limit;
        wait (table_ready);
        limit = 1000;
        foreach (rows[i]) limit += (rows[i].budget + 40) * 4;
        #(limit);
        $display("watchdog: simulation ran past its time limit");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        enable    = 1'b0;
        bus_rstn  = 1'b0;
        lvbl      = 1'b1;
        nmi_n     = 1'b1;
        dip_pause = 1'b0;
        busrq_n   = 1'b1;
        cen       = 1'b1;
        rom_lat   = 3'd0;
        main_drive(1'b0, 1'b0, 11'h0, 8'h00);
        rng       = 32'ha02f_b2c8;
        errors    = 0;
        failed    = 0;
        //       name           prog pz  lp  nmi en b  rq    c  rn w  expect  budget
        add_row("arith",        0, 0, 0,  -1, 1, 1, 0, 0,  0, 0, 0,
                8'((8'hA7 + 8'h6B) * 2), 200);
        add_row("rom_latency",  0, 0, 0,  -1, 1, 1, 0, 0,  0, 1, 0,
                8'((8'hA7 + 8'h6B) * 2), 500);
        add_row("contention",   1, 0, 0,  -1, 1, 1, 0, 0,  1, 1, 0,
                8'((8'h11 + 8'h33) * 2), 600);
        add_row("int_paused",   2, 1, 32, -1, 1, 1, 0, 0,  0, 0, 0, 8'h55, 300);
        add_row("int_masked",   2, 0, 32, -1, 1, 1, 0, 0,  0, 0, 1, 8'h11, 300);
        add_row("nmi",          3, 0, 0,  40, 1, 1, 0, 0,  0, 0, 0, 8'hA5, 300);
        add_row("enable_low",   0, 0, 0,  -1, 0, 1, 0, 0,  0, 0, 1, SENT, 150);
        add_row("bus_rstn_low", 0, 0, 0,  -1, 1, 0, 0, 0,  0, 0, 1, SENT, 150);
        add_row("busrq",        0, 0, 0,  -1, 1, 1, 3, 80, 0, 0, 0,
                8'((8'hA7 + 8'h6B) * 2), 300);
        table_ready = 1;
        foreach (rows[i]) run_test(rows[i]);
        $display("%0d tests, %0d failed, %0d errors", rows.size(), failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== flstory_sub.f ====
hw/flstory_pkg.sv
hw/flstory_sub_cpu.sv
hw/flstory_sub.sv
hw/flstory_shared_ram.sv
hw/flstory_sub_top.sv
tb/flstory_rom_model.sv
tb/flstory_sub_tb.sv
